// ==== cheat_engine.f ====
rtl/cheat_pkg.sv
rtl/cheat_port_if.sv
rtl/cheat_prog_store.sv
rtl/cheat_sequencer.sv
rtl/cheat_port_regs.sv
rtl/cheat_sdram_arb.sv
rtl/cheat_engine.sv
tests/cheat_engine_tb.sv

// ==== rtl/cheat_engine.sv ====
//==========================================================
// Cheat engine top level
// Program store, sequencer, port registers and bank 0
// arbiter, plus the registered core reset
//==========================================================
`timescale 1ns/100ps

module cheat_engine (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   lvbl,
    input  cheat_pkg::sdram_addr_t game_addr,
    input  logic                   game_rd,
    input  logic                   game_wr,
    input  cheat_pkg::sdram_data_t game_din,
    input  cheat_pkg::sdram_mask_t game_din_m,
    output logic                   game_ack,
    output logic                   game_dst,
    output logic                   game_rdy,
    output cheat_pkg::sdram_addr_t ba0_addr,
    output logic                   ba0_rd,
    output logic                   ba0_wr,
    output cheat_pkg::sdram_data_t ba0_din,
    output cheat_pkg::sdram_mask_t ba0_din_m,
    input  logic                   ba0_ack,
    input  logic                   ba0_dst,
    input  logic                   ba0_rdy,
    input  cheat_pkg::sdram_data_t data_read,
    input  logic [31:0]            flags,
    input  cheat_pkg::port_data_t  joy0,
    output logic                   led,
    output cheat_pkg::port_data_t  st_addr,
    input  cheat_pkg::port_data_t  st_dout,
    input  cheat_pkg::port_data_t  debug_bus,
    output logic [9:0]             vram_addr,
    output cheat_pkg::port_data_t  vram_dout,
    input  cheat_pkg::port_data_t  vram_din,
    output logic                   vram_we,
    output logic [2:0]             vram_ctrl,
    input  logic                   prog_en,
    input  logic                   prog_wr,
    input  cheat_pkg::port_data_t  prog_data
);

    cheat_pkg::prog_addr_t  fetch_addr;
    cheat_pkg::prog_word_t  fetch_word;
    cheat_pkg::sdram_addr_t addr;
    cheat_pkg::sdram_data_t din;
    cheat_pkg::sdram_mask_t din_m;
    cheat_pkg::sdram_data_t rd_data;
    logic                   req;
    logic                   req_wr;
    logic                   cheat_ack;
    logic                   cheat_dst;
    logic                   owner;
    logic                   cheat_busy;
    logic                   wdog_expire;
    logic                   core_rst;

    cheat_port_if port_bus ();

    // Restart one cycle after watchdog expiry
    always_ff @(posedge clk) begin
        core_rst <= prst | wdog_expire;
    end

    cheat_prog_store prog_store_inst (
        .clk        (clk),
        .prst       (prst),
        .prog_en    (prog_en),
        .prog_wr    (prog_wr),
        .prog_data  (prog_data),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word)
    );

    cheat_sequencer sequencer_inst (
        .clk        (clk),
        .core_rst   (core_rst),
        .prog_en    (prog_en),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .port       (port_bus.sequencer)
    );

    cheat_port_regs port_regs_inst (
        .clk         (clk),
        .prst        (prst),
        .core_rst    (core_rst),
        .port        (port_bus.regs),
        .lvbl        (lvbl),
        .flags       (flags),
        .joy0        (joy0),
        .debug_bus   (debug_bus),
        .st_dout     (st_dout),
        .vram_din    (vram_din),
        .st_addr     (st_addr),
        .vram_addr   (vram_addr),
        .vram_dout   (vram_dout),
        .vram_we     (vram_we),
        .vram_ctrl   (vram_ctrl),
        .led         (led),
        .req         (req),
        .req_wr      (req_wr),
        .addr        (addr),
        .din         (din),
        .din_m       (din_m),
        .cheat_ack   (cheat_ack),
        .cheat_dst   (cheat_dst),
        .rd_data     (rd_data),
        .owner       (owner),
        .cheat_busy  (cheat_busy),
        .wdog_expire (wdog_expire)
    );

    cheat_sdram_arb sdram_arb_inst (
        .clk        (clk),
        .prst       (prst),
        .game_addr  (game_addr),
        .game_rd    (game_rd),
        .game_wr    (game_wr),
        .game_din   (game_din),
        .game_din_m (game_din_m),
        .game_ack   (game_ack),
        .game_dst   (game_dst),
        .game_rdy   (game_rdy),
        .req        (req),
        .req_wr     (req_wr),
        .addr       (addr),
        .din        (din),
        .din_m      (din_m),
        .cheat_ack  (cheat_ack),
        .cheat_dst  (cheat_dst),
        .rd_data    (rd_data),
        .owner      (owner),
        .cheat_busy (cheat_busy),
        .ba0_addr   (ba0_addr),
        .ba0_rd     (ba0_rd),
        .ba0_wr     (ba0_wr),
        .ba0_din    (ba0_din),
        .ba0_din_m  (ba0_din_m),
        .ba0_ack    (ba0_ack),
        .ba0_dst    (ba0_dst),
        .ba0_rdy    (ba0_rdy),
        .data_read  (data_read)
    );

endmodule

// ==== rtl/cheat_pkg.sv ====
//==========================================================
// Cheat engine shared definitions
// Widths, typedefs, opcode and sequencer state enums,
// port map and watchdog constants
//==========================================================
package cheat_pkg;

    // Program store geometry
    localparam int PROG_AW    = 10;
    localparam int PROG_WORDS = 1024;

    typedef logic [21:0]        sdram_addr_t;
    typedef logic [15:0]        sdram_data_t;
    typedef logic [1:0]         sdram_mask_t;
    typedef logic [7:0]         port_id_t;
    typedef logic [7:0]         port_data_t;
    typedef logic [PROG_AW-1:0] prog_addr_t;
    // Opcode in 17:16, port in 15:8, data in 7:0
    typedef logic [17:0]        prog_word_t;
    typedef logic [4:0]         wdog_cnt_t;

    typedef enum logic [1:0] {
        OP_OUT  = 2'd0,
        OP_POLL = 2'd1,
        OP_JUMP = 2'd2,
        OP_HALT = 2'd3
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        READ,
        TEST,
        HALTED
    } seq_state_e;

    // Port map
    localparam port_id_t PORT_SDRAM_LO  = 8'd0;
    localparam port_id_t PORT_LED       = 8'd6;
    localparam port_id_t PORT_RD_HI     = 8'd7;
    localparam port_id_t PORT_VRAM_AL   = 8'd8;
    localparam port_id_t PORT_VRAM_AH   = 8'd9;
    localparam port_id_t PORT_VRAM_WR   = 8'd10;
    localparam port_id_t PORT_VRAM_CTL  = 8'd11;
    localparam port_id_t PORT_ST_ADDR   = 8'd12;
    localparam port_id_t PORT_ST_DATA   = 8'd13;
    localparam port_id_t PORT_DEBUG     = 8'd15;
    localparam port_id_t PORT_FLAGS     = 8'd16;
    localparam port_id_t PORT_JOY       = 8'd24;
    localparam port_id_t PORT_KICK_BASE = 8'd64;
    localparam port_id_t PORT_SDRAM_REQ = 8'd128;
    localparam port_id_t PORT_STATUS    = 8'd128;

    // Blank starts without a kick before a restart
    localparam wdog_cnt_t WDOG_BLANKS = 5'd16;

endpackage

// ==== rtl/cheat_port_if.sv ====
//==========================================================
// Port bus between the script sequencer and the
// port register block
//==========================================================
`timescale 1ns/100ps

interface cheat_port_if;

    cheat_pkg::port_id_t   port_id;
    cheat_pkg::port_data_t out_data;
    logic                  wr;
    logic                  rd;
    // Valid from the cycle after rd
    cheat_pkg::port_data_t in_data;

    modport sequencer (
        output port_id, out_data, wr, rd,
        input  in_data
    );

    modport regs (
        input  port_id, out_data, wr, rd,
        output in_data
    );

endinterface

// ==== rtl/cheat_port_regs.sv ====
//==========================================================
// Port register block
// SDRAM request bytes, VRAM port, status address, LED,
// vertical blank watchdog and the registered read mux
//==========================================================
`timescale 1ns/100ps

module cheat_port_regs (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   core_rst,
    cheat_port_if.regs             port,
    input  logic                   lvbl,
    input  logic [31:0]            flags,
    input  cheat_pkg::port_data_t  joy0,
    input  cheat_pkg::port_data_t  debug_bus,
    input  cheat_pkg::port_data_t  st_dout,
    input  cheat_pkg::port_data_t  vram_din,
    output cheat_pkg::port_data_t  st_addr,
    output logic [9:0]             vram_addr,
    output cheat_pkg::port_data_t  vram_dout,
    output logic                   vram_we,
    output logic [2:0]             vram_ctrl,
    output logic                   led,
    output logic                   req,
    output logic                   req_wr,
    output cheat_pkg::sdram_addr_t addr,
    output cheat_pkg::sdram_data_t din,
    output cheat_pkg::sdram_mask_t din_m,
    input  logic                   cheat_ack,
    input  logic                   cheat_dst,
    input  cheat_pkg::sdram_data_t rd_data,
    input  logic                   owner,
    input  logic                   cheat_busy,
    output logic                   wdog_expire
);

    cheat_pkg::port_data_t  sdram_regs [0:5];
    cheat_pkg::sdram_data_t rd_q;
    cheat_pkg::wdog_cnt_t   wdog_cnt;
    logic                   lvbl_last;
    logic                   blank_start;
    logic                   kick;

    assign addr        = {sdram_regs[2][5:0], sdram_regs[1], sdram_regs[0]};
    assign din         = {sdram_regs[4], sdram_regs[3]};
    assign din_m       = sdram_regs[5][1:0];
    assign blank_start = lvbl_last & ~lvbl;
    assign kick        = port.wr && port.port_id[7:6] == cheat_pkg::PORT_KICK_BASE[7:6];
    assign wdog_expire = wdog_cnt == cheat_pkg::WDOG_BLANKS;

    // Payload bytes
    always_ff @(posedge clk) begin
        if (port.wr) begin
            if (port.port_id < cheat_pkg::PORT_LED) begin
                sdram_regs[port.port_id[2:0]] <= port.out_data;
            end
            case (port.port_id)
                cheat_pkg::PORT_VRAM_AL: vram_addr[4:0] <= port.out_data[4:0];
                cheat_pkg::PORT_VRAM_AH: vram_addr[9:5] <= port.out_data[4:0];
                cheat_pkg::PORT_VRAM_WR: vram_dout      <= port.out_data;
                cheat_pkg::PORT_ST_ADDR: st_addr        <= port.out_data;
                default: ;
            endcase
        end
        if (cheat_dst) begin
            rd_q <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            vram_we   <= 1'b0;
            vram_ctrl <= 3'd0;
            led       <= 1'b0;
        end else begin
            vram_we <= port.wr && port.port_id == cheat_pkg::PORT_VRAM_WR;
            if (port.wr && port.port_id == cheat_pkg::PORT_VRAM_CTL) begin
                vram_ctrl <= port.out_data[2:0];
            end
            if (port.wr && port.port_id == cheat_pkg::PORT_LED) begin
                led <= port.out_data[0];
            end
        end
    end

    // SDRAM request and LVBL edge register
    always_ff @(posedge clk) begin
        if (prst) begin
            req       <= 1'b0;
            req_wr    <= 1'b0;
            lvbl_last <= 1'b0;
        end else begin
            lvbl_last <= lvbl;
            if (!req && port.wr && port.port_id >= cheat_pkg::PORT_SDRAM_REQ) begin
                req    <= 1'b1;
                req_wr <= port.port_id[6];
            end else if (cheat_ack) begin
                req <= 1'b0;
            end
        end
    end

    // Watchdog on falling LVBL
    always_ff @(posedge clk) begin
        if (core_rst || kick) begin
            wdog_cnt <= '0;
        end else if (blank_start && !wdog_expire) begin
            wdog_cnt <= wdog_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            port.in_data <= '0;
        end else if (port.rd) begin
            case (port.port_id)
                cheat_pkg::PORT_LED:     port.in_data <= rd_q[7:0];
                cheat_pkg::PORT_RD_HI:   port.in_data <= rd_q[15:8];
                cheat_pkg::PORT_VRAM_WR: port.in_data <= vram_din;
                cheat_pkg::PORT_ST_DATA: port.in_data <= st_dout;
                cheat_pkg::PORT_DEBUG:   port.in_data <= debug_bus;
                cheat_pkg::PORT_JOY:     port.in_data <= joy0;
                // Busy covers a pending request as well
                cheat_pkg::PORT_STATUS:
                    port.in_data <= {owner, req | cheat_busy, lvbl, 5'd0};
                default: begin
                    if (port.port_id[7:3] == cheat_pkg::PORT_SDRAM_LO[7:3]) begin
                        port.in_data <= sdram_regs[port.port_id[2:0]];
                    end else if (port.port_id[7:2] == cheat_pkg::PORT_FLAGS[7:2]) begin
                        port.in_data <= flags[{port.port_id[1:0], 3'b000} +: 8];
                    end else begin
                        port.in_data <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/cheat_prog_store.sv ====
//==========================================================
// Program word RAM
// Byte-serial loader, three bytes per word, and a
// registered fetch port
//==========================================================
`timescale 1ns/100ps

module cheat_prog_store (
    input  logic                  clk,
    input  logic                  prst,
    input  logic                  prog_en,
    input  logic                  prog_wr,
    input  cheat_pkg::port_data_t prog_data,
    input  cheat_pkg::prog_addr_t fetch_addr,
    output cheat_pkg::prog_word_t fetch_word
);

    cheat_pkg::prog_word_t ram [0:cheat_pkg::PROG_WORDS-1];
    cheat_pkg::prog_addr_t load_addr;
    logic [1:0]            byte_phase;
    logic [1:0]            op_byte;
    cheat_pkg::port_data_t mid_byte;

    // Counters rest at zero outside a load
    always_ff @(posedge clk) begin
        if (prst || !prog_en) begin
            byte_phase <= 2'd0;
            load_addr  <= '0;
        end else if (prog_wr) begin
            if (byte_phase == 2'd2) begin
                byte_phase <= 2'd0;
                load_addr  <= load_addr + 1'b1;
            end else begin
                byte_phase <= byte_phase + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_en && prog_wr) begin
            case (byte_phase)
                2'd0:    op_byte  <= prog_data[1:0];
                2'd1:    mid_byte <= prog_data;
                default: ram[load_addr] <= {op_byte, mid_byte, prog_data};
            endcase
        end
        fetch_word <= ram[fetch_addr];
    end

endmodule

// ==== rtl/cheat_sdram_arb.sv ====
//==========================================================
// SDRAM bank 0 arbiter
// Game priority on an idle bank, request mux and
// response gating by owner
//==========================================================
`timescale 1ns/100ps

module cheat_sdram_arb (
    input  logic                   clk,
    input  logic                   prst,
    input  cheat_pkg::sdram_addr_t game_addr,
    input  logic                   game_rd,
    input  logic                   game_wr,
    input  cheat_pkg::sdram_data_t game_din,
    input  cheat_pkg::sdram_mask_t game_din_m,
    output logic                   game_ack,
    output logic                   game_dst,
    output logic                   game_rdy,
    input  logic                   req,
    input  logic                   req_wr,
    input  cheat_pkg::sdram_addr_t addr,
    input  cheat_pkg::sdram_data_t din,
    input  cheat_pkg::sdram_mask_t din_m,
    output logic                   cheat_ack,
    output logic                   cheat_dst,
    output cheat_pkg::sdram_data_t rd_data,
    output logic                   owner,
    output logic                   cheat_busy,
    output cheat_pkg::sdram_addr_t ba0_addr,
    output logic                   ba0_rd,
    output logic                   ba0_wr,
    output cheat_pkg::sdram_data_t ba0_din,
    output cheat_pkg::sdram_mask_t ba0_din_m,
    input  logic                   ba0_ack,
    input  logic                   ba0_dst,
    input  logic                   ba0_rdy,
    input  cheat_pkg::sdram_data_t data_read
);

    logic busy;
    logic game_req;
    logic cheat_sel;

    assign game_req = game_rd | game_wr;
    // An idle bank goes to the game in the cycle it asks
    assign cheat_sel = busy ? owner : (req & ~game_req);

    always_ff @(posedge clk) begin
        if (prst) begin
            busy       <= 1'b0;
            owner      <= 1'b0;
            cheat_busy <= 1'b0;
        end else begin
            if (ba0_rdy) begin
                busy <= 1'b0;
                if (owner) begin
                    cheat_busy <= 1'b0;
                end
            end
            if (!busy && (game_req || req)) begin
                busy       <= 1'b1;
                owner      <= cheat_sel;
                cheat_busy <= cheat_sel;
            end
        end
    end

    assign ba0_addr  = cheat_sel ? addr : game_addr;
    assign ba0_rd    = cheat_sel ? (req & ~req_wr) : game_rd;
    assign ba0_wr    = cheat_sel ? (req & req_wr) : game_wr;
    assign ba0_din   = cheat_sel ? din : game_din;
    assign ba0_din_m = cheat_sel ? din_m : game_din_m;

    assign game_ack  = ~cheat_sel & ba0_ack;
    assign game_dst  = ~cheat_sel & ba0_dst;
    assign game_rdy  = ~cheat_sel & ba0_rdy;
    assign cheat_ack = cheat_sel & ba0_ack;
    assign cheat_dst = cheat_sel & ba0_dst;
    assign rd_data   = data_read;

endmodule

// ==== rtl/cheat_sequencer.sv ====
//==========================================================
// Script sequencer
// Fetch and execute FSM for OUT, POLL, JUMP and HALT
//==========================================================
`timescale 1ns/100ps

module cheat_sequencer (
    input  logic                  clk,
    input  logic                  core_rst,
    input  logic                  prog_en,
    output cheat_pkg::prog_addr_t fetch_addr,
    input  cheat_pkg::prog_word_t fetch_word,
    cheat_port_if.sequencer       port
);

    cheat_pkg::seq_state_e state;
    cheat_pkg::prog_addr_t pc;
    cheat_pkg::port_data_t poll_mask;
    cheat_pkg::opcode_e    op;
    cheat_pkg::port_id_t   op_port;
    cheat_pkg::port_data_t op_data;

    assign fetch_addr = pc;
    assign op         = cheat_pkg::opcode_e'(fetch_word[17:16]);
    assign op_port    = fetch_word[15:8];
    assign op_data    = fetch_word[7:0];

    // Operands of the decoded word stay put through polling
    always_ff @(posedge clk) begin
        if (state == cheat_pkg::DECODE) begin
            port.port_id  <= op_port;
            port.out_data <= op_data;
            poll_mask     <= op_data;
        end
    end

    always_ff @(posedge clk) begin
        if (core_rst || prog_en) begin
            state   <= cheat_pkg::FETCH;
            pc      <= '0;
            port.wr <= 1'b0;
            port.rd <= 1'b0;
        end else begin
            port.wr <= 1'b0;
            port.rd <= 1'b0;
            case (state)
                // RAM read in flight
                cheat_pkg::FETCH: state <= cheat_pkg::DECODE;
                cheat_pkg::DECODE: begin
                    case (op)
                        cheat_pkg::OP_OUT: begin
                            port.wr <= 1'b1;
                            pc      <= pc + 1'b1;
                            state   <= cheat_pkg::FETCH;
                        end
                        cheat_pkg::OP_POLL: begin
                            port.rd <= 1'b1;
                            state   <= cheat_pkg::READ;
                        end
                        cheat_pkg::OP_JUMP: begin
                            pc    <= {op_data, 2'b00};
                            state <= cheat_pkg::FETCH;
                        end
                        default: state <= cheat_pkg::HALTED;
                    endcase
                end
                // Port block registers in_data during this cycle
                cheat_pkg::READ: state <= cheat_pkg::TEST;
                cheat_pkg::TEST: begin
                    if ((port.in_data & poll_mask) == '0) begin
                        pc    <= pc + 1'b1;
                        state <= cheat_pkg::FETCH;
                    end else begin
                        port.rd <= 1'b1;
                        state   <= cheat_pkg::READ;
                    end
                end
                default: state <= cheat_pkg::HALTED;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cheat engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module cheat_engine_tb \
    -f cheat_engine.f \
    --Mdir obj_dir \
    -o cheat_engine_sim

./obj_dir/cheat_engine_sim

// ==== tests/cheat_engine_tb.sv ====
//==========================================================
// Cheat engine testbench
// Clock, reset, program loader, bank 0 and game models,
// LVBL source, value checks and run timeout
//==========================================================
`timescale 1ns/100ps

module cheat_engine_tb;

    logic                   clk = 1'b0;
    logic                   prst;
    logic                   lvbl;
    cheat_pkg::sdram_addr_t game_addr;
    logic                   game_rd;
    logic                   game_wr;
    cheat_pkg::sdram_data_t game_din;
    cheat_pkg::sdram_mask_t game_din_m;
    logic                   game_ack;
    logic                   game_dst;
    logic                   game_rdy;
    cheat_pkg::sdram_addr_t ba0_addr;
    logic                   ba0_rd;
    logic                   ba0_wr;
    cheat_pkg::sdram_data_t ba0_din;
    cheat_pkg::sdram_mask_t ba0_din_m;
    logic                   ba0_ack;
    logic                   ba0_dst;
    logic                   ba0_rdy;
    cheat_pkg::sdram_data_t data_read;
    logic                   led;
    cheat_pkg::port_data_t  st_addr;
    logic [9:0]             vram_addr;
    cheat_pkg::port_data_t  vram_dout;
    logic                   vram_we;
    logic [2:0]             vram_ctrl;
    logic                   prog_en;
    logic                   prog_wr;
    cheat_pkg::port_data_t  prog_data;

    logic [15:0] td [0:127];
    int          exp_base;
    int          blank_falls;
    // Bank model state
    int                     bank_cnt;
    cheat_pkg::sdram_addr_t cap_addr;
    cheat_pkg::sdram_data_t cap_din;
    cheat_pkg::sdram_mask_t cap_mask;
    logic                   cap_wr;
    logic                   ack_next;
    logic                   rdy_next;
    // Game model state
    int                     gstate;
    logic [31:0]            rnd;
    cheat_pkg::sdram_addr_t g_addr;
    cheat_pkg::sdram_data_t g_din;
    cheat_pkg::sdram_mask_t g_mask;
    logic                   g_wr;
    int                     game_done;
    // Observed cheat traffic
    int                     cheat_wr_count;
    int                     cheat_rd_count;
    int                     vram_count;
    logic [17:0]            vram_log [0:7];

    cheat_engine cheat_engine_inst (.*, .flags(32'h0), .joy0(8'h0), .st_dout(8'h0),
        .debug_bus(8'h0), .vram_din(8'h0));

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            abort($sformatf("Fail %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_program(input int base);
        int n;
        int i;
        n = int'(td[base]);
        @(posedge clk);
        #1 prog_en = 1'b1;
        @(posedge clk);
        #1;
        for (i = 0; i < 3 * n; i++) begin
            prog_wr   = 1'b1;
            prog_data = td[base + 1 + i][7:0];
            @(posedge clk);
            #1;
        end
        prog_wr = 1'b0;
        prog_en = 1'b0;
    endtask

    // Falling edge every 400 cycles
    initial begin
        forever begin
            repeat (200) @(posedge clk);
            #1 lvbl = ~lvbl;
            if (!lvbl) begin
                blank_falls++;
            end
        end
    end

    // Sample everything mid-cycle, outputs settle by then
    always @(negedge clk) begin
        if (vram_we) begin
            vram_log[vram_count[2:0]] = {vram_addr, vram_dout};
            vram_count++;
        end
        ack_next = 1'b0;
        rdy_next = 1'b0;
        if (bank_cnt == 0) begin
            if ((ba0_rd || ba0_wr) && !ba0_rdy) begin
                bank_cnt = 1;
                cap_addr = ba0_addr;
                cap_din  = ba0_din;
                cap_mask = ba0_din_m;
                cap_wr   = ba0_wr;
                // Cheat addresses have bit 21 clear
                if (!ba0_addr[21]) begin
                    check_value("cheat addr", 32'(td[exp_base + 5]), 32'(ba0_addr));
                    if (ba0_wr) begin
                        check_value("cheat data", 32'(td[exp_base + 6]), 32'(ba0_din));
                        check_value("cheat mask", 32'(td[exp_base + 7]), 32'(ba0_din_m));
                        cheat_wr_count++;
                    end else begin
                        cheat_rd_count++;
                    end
                end
            end
        end else begin
            bank_cnt++;
            ack_next = (bank_cnt == 2);
            if (bank_cnt == 4) begin
                rdy_next = 1'b1;
                bank_cnt = 0;
            end
        end

        if (game_ack && gstate != 1) begin
            abort("Game ack arrived with no game request pending");
        end
        if ((game_dst || game_rdy) && gstate != 2) begin
            abort("Game dst or rdy arrived with no game access in flight");
        end
        case (gstate)
            1: begin
                if (game_ack) begin
                    check_value("game addr", 32'(g_addr), 32'(cap_addr));
                    check_value("game write", 32'(g_wr), 32'(cap_wr));
                    if (g_wr) begin
                        check_value("game data", 32'(g_din), 32'(cap_din));
                        check_value("game mask", 32'(g_mask), 32'(cap_mask));
                    end
                    gstate = 2;
                end
            end
            2: begin
                // Bank model raises dst together with rdy
                if (game_rdy) begin
                    check_value("game dst", 32'd1, 32'(game_dst));
                    gstate = 0;
                    game_done++;
                end
            end
            default: begin
                rnd = lcg_next(rnd);
                if (rnd[1:0] == 2'd0 && !prst) begin
                    g_addr = {1'b1, rnd[20:0]};
                    g_wr   = rnd[8];
                    g_din  = rnd[31:16];
                    g_mask = rnd[3:2];
                    gstate = 1;
                end
            end
        endcase
    end

    always @(posedge clk) begin
        #1;
        ba0_ack    = ack_next;
        ba0_dst    = rdy_next;
        ba0_rdy    = rdy_next;
        data_read  = cap_addr[15:0];
        game_rd    = (gstate == 1) && !g_wr;
        game_wr    = (gstate == 1) && g_wr;
        game_addr  = g_addr;
        game_din   = g_din;
        game_din_m = g_mask;
    end

    // Timeout from the program lengths plus two watchdog periods
    initial begin
        int limit;
        #1;
        limit = 300 * (int'(td[0]) + int'(td[1 + 3 * int'(td[0])]))
                + 2 * 17 * 400 + 2000;
        repeat (limit) @(posedge clk);
        abort("Timeout: the DUT did not reach the expected state in time");
    end

    initial begin
        prst = 1'b1;
        lvbl = 1'b1;
        prog_en = 1'b0;
        prog_wr = 1'b0;
        prog_data = '0;
        {ba0_ack, ba0_dst, ba0_rdy, game_rd, game_wr} = '0;
        {ack_next, rdy_next, cap_wr, g_wr} = '0;
        data_read = '0;
        {game_addr, cap_addr, g_addr} = '0;
        {game_din, cap_din, g_din} = '0;
        {game_din_m, cap_mask, g_mask} = '0;
        {bank_cnt, gstate, game_done} = '0;
        {cheat_wr_count, cheat_rd_count, vram_count} = '0;
        blank_falls = 0;
        rnd = 32'h86604349;
        $readmemh("tests/cheat_testdata.txt", td);
        exp_base = 1 + 3 * int'(td[0]);
        exp_base = exp_base + 1 + 3 * int'(td[exp_base]);
        repeat (16) @(posedge clk);
        #1 prst = 1'b0;
        check_value("reset led", 32'd0, 32'(led));
        check_value("reset vram_we", 32'd0, 32'(vram_we));
        check_value("reset vram_ctrl", 32'd0, 32'(vram_ctrl));

        load_program(0);
        wait (vram_count >= 1);
        check_value("vram addr", 32'(td[exp_base]), 32'(vram_log[0][17:8]));
        check_value("vram data", 32'(td[exp_base + 1]), 32'(vram_log[0][7:0]));
        wait (cheat_wr_count >= 1);
        check_value("led", 32'(td[exp_base + 3]), 32'(led));
        check_value("st_addr", 32'(td[exp_base + 4]), 32'(st_addr));
        // Marker write follows the read-back polls
        wait (vram_count >= 2);
        check_value("read marker", 32'(td[exp_base + 2]), 32'(vram_log[1][7:0]));
        check_value("cheat reads", 32'd1, 32'(cheat_rd_count));

        load_program(1 + 3 * int'(td[0]));
        wait (led == 1'b0);
        wait (led == 1'b1);
        // No kick since reset, so the restart follows the 16th blank start
        check_value("blank starts", 32'd16, 32'(blank_falls));
        check_value("game accesses seen", 32'd1, 32'(game_done > 0));
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tests/cheat_testdata.txt ====
// Program records: word count, then one word per line as opcode port data
// Expected: vram addr, vram data, marker data, led, st_addr, sdram addr, data, mask
0013
00 08 05
00 09 03
00 0a a5
00 06 01
00 0c 3c
00 00 34
00 01 12
00 02 00
00 03 cd
00 04 ab
00 05 01
00 c0 00
01 80 40
00 80 00
01 80 40
01 06 cb
01 07 ed
00 0a 5a
03 00 00
// Watchdog program: led on, led off, halt without a kick
0003
00 06 01
00 06 00
03 00 00
// Expected values
0065 00a5 005a 0001 003c 1234 abcd 0001
